// ==== common/or1420Pkg.sv ====
`default_nettype none

package or1420Pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // custom-instruction bus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int dataWidth = 32;      // operand and result width
  localparam int ciNumberWidth = 8;

  // instruction numbers as the processor encodes them
  typedef enum logic [ciNumberWidth-1:0] {
    ciSwapByte   = 8'd1,
    ciDelayMicro = 8'd6
  } ciNumberT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shared bus and reset
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int nrOfBusMasters = 32; // bit 31 wins

  // msb of the counter ends the reset after 16 cycles
  localparam int resetCountWidth = 5;

  typedef enum logic [1:0] {
    idle,       // nobody owns the bus
    waitBegin,  // granted, master not started yet
    busy        // transaction running
  } arbiterStateT;

endpackage

`default_nettype wire

// ==== customInstructions/swapByte.sv ====
`timescale 1ns/1ns
`default_nettype none

module swapByte #(
  parameter logic [or1420Pkg::ciNumberWidth-1:0] customInstructionId = or1420Pkg::ciSwapByte
) (
  input  wire logic                              ciStart,
  input  wire logic [or1420Pkg::ciNumberWidth-1:0] ciNumber,
  input  wire logic [or1420Pkg::dataWidth-1:0]   ciDataA,
  input  wire logic [or1420Pkg::dataWidth-1:0]   ciDataB,
  output logic                                   ciDone,
  output logic [or1420Pkg::dataWidth-1:0]        ciResult
);

  logic                              s_selected;
  logic [or1420Pkg::dataWidth-1:0]   s_wordReversed;
  logic [or1420Pkg::dataWidth-1:0]   s_halfSwapped;

  assign s_selected = ciStart && (ciNumber == customInstructionId);

  // byte 0 ends up in byte 3
  assign s_wordReversed = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};

  // bytes swapped inside each half
  assign s_halfSwapped = {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]};

  assign ciDone = s_selected;   // single cycle instruction

  always_comb begin
    ciResult = '0;
    if (s_selected) begin
      if (ciDataB[0]) begin
        ciResult = s_halfSwapped;
      end else begin
        ciResult = s_wordReversed;
      end
    end
  end

endmodule

`default_nettype wire

// ==== customInstructions/delayMicro.sv ====
`timescale 1ns/1ns
`default_nettype none

module delayMicro #(
  parameter logic [or1420Pkg::ciNumberWidth-1:0] customInstructionId = or1420Pkg::ciDelayMicro,
  parameter int ticksPerMicrosecond = 50
) (
  input  wire logic                                s_systemClock,
  input  wire logic                                reset,
  input  wire logic                                ciStart,
  input  wire logic [or1420Pkg::ciNumberWidth-1:0] ciNumber,
  input  wire logic [or1420Pkg::dataWidth-1:0]     ciDataA,
  output logic                                     ciDone,
  output logic [or1420Pkg::dataWidth-1:0]          ciResult
);

  localparam int prescalerWidth = (ticksPerMicrosecond > 1) ? $clog2(ticksPerMicrosecond) : 1;
  localparam logic [prescalerWidth-1:0] prescalerReload = prescalerWidth'(ticksPerMicrosecond - 1);

  logic                                s_selected;
  logic                                s_busy;
  logic                                s_doneReg;
  logic [prescalerWidth-1:0]           s_prescaler;
  logic [or1420Pkg::dataWidth-1:0]     s_microCount;

  assign s_selected = ciStart && (ciNumber == customInstructionId);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // microsecond counter with tick prescaler
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      s_busy       <= 1'b0;
      s_doneReg    <= 1'b0;
      s_prescaler  <= '0;
      s_microCount <= '0;
    end else begin
      s_doneReg <= 1'b0;
      if (!s_busy) begin
        if (s_selected) begin
          s_busy       <= 1'b1;
          s_microCount <= ciDataA;
          s_prescaler  <= prescalerReload;
          s_doneReg    <= (ciDataA == '0);   // zero delay finishes at once
        end
      end else if (s_microCount != '0) begin
        if (s_prescaler == '0) begin
          s_prescaler  <= prescalerReload;
          s_microCount <= s_microCount - 1'b1;
          s_doneReg    <= (s_microCount == 1);
        end else begin
          s_prescaler <= s_prescaler - 1'b1;
        end
      end else if (!s_selected) begin
        // wait for the processor to drop the start after done
        s_busy <= 1'b0;
      end
    end
  end

  assign ciDone   = s_doneReg;
  assign ciResult = '0;   // delay returns no value

endmodule

`default_nettype wire

// ==== busArbiter/busArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module busArbiter #(
  parameter int busTimeoutCycles = 64
) (
  input  wire logic                                 s_systemClock,
  input  wire logic                                 reset,
  input  wire logic [or1420Pkg::nrOfBusMasters-1:0] busRequests,
  input  wire logic                                 beginTransaction,
  input  wire logic                                 endTransaction,
  input  wire logic                                 dataValid,
  output logic [or1420Pkg::nrOfBusMasters-1:0]      busGrants,
  output logic                                      busError,
  output logic                                      arbiterEndTransaction,
  output logic                                      busIdle
);

  localparam int timeoutWidth = $clog2(busTimeoutCycles + 1);
  localparam logic [timeoutWidth-1:0] timeoutLast = timeoutWidth'(busTimeoutCycles - 1);

  or1420Pkg::arbiterStateT                  s_state;
  logic [or1420Pkg::nrOfBusMasters-1:0]     s_grantSelect;
  logic [or1420Pkg::nrOfBusMasters-1:0]     s_grantReg;
  logic [timeoutWidth-1:0]                  s_timeoutCount;
  logic                                     s_timeoutPulse;
  logic                                     s_busActivity;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fixed priority, highest set request wins
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    s_grantSelect = '0;
    for (int i = 0; i < or1420Pkg::nrOfBusMasters; i++) begin
      if (busRequests[i]) begin
        s_grantSelect    = '0;   // a higher bit overrides
        s_grantSelect[i] = 1'b1;
      end
    end
  end

  assign s_busActivity = beginTransaction | endTransaction | dataValid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      s_state <= or1420Pkg::idle;
    end else begin
      case (s_state)
        or1420Pkg::idle: begin
          if (busRequests != '0) begin
            s_state <= or1420Pkg::waitBegin;
          end
        end
        or1420Pkg::waitBegin: begin
          if (s_timeoutPulseNext()) begin
            s_state <= or1420Pkg::idle;
          end else if (beginTransaction) begin
            s_state <= or1420Pkg::busy;
          end
        end
        or1420Pkg::busy: begin
          if (endTransaction || s_timeoutPulseNext()) begin
            s_state <= or1420Pkg::idle;
          end
        end
        default: s_state <= or1420Pkg::idle;
      endcase
    end
  end

  // last silent cycle of an owned bus
  function automatic logic s_timeoutPulseNext();
    return !s_busActivity && (s_timeoutCount == timeoutLast);
  endfunction

  // grant is a single cycle pulse
  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      s_grantReg <= '0;
    end else if (s_state == or1420Pkg::idle) begin
      s_grantReg <= s_grantSelect;
    end else begin
      s_grantReg <= '0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // inactivity timeout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      s_timeoutCount <= '0;
      s_timeoutPulse <= 1'b0;
    end else begin
      s_timeoutPulse <= 1'b0;
      if (s_state == or1420Pkg::idle || s_busActivity) begin
        s_timeoutCount <= '0;
      end else if (s_timeoutCount == timeoutLast) begin
        s_timeoutCount <= '0;
        s_timeoutPulse <= 1'b1;   // abort the stuck master
      end else begin
        s_timeoutCount <= s_timeoutCount + 1'b1;
      end
    end
  end

  assign busGrants             = s_grantReg;
  assign busError              = s_timeoutPulse;
  assign arbiterEndTransaction = s_timeoutPulse;
  assign busIdle               = (s_state == or1420Pkg::idle);

endmodule

`default_nettype wire

// ==== source/or1420Subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module or1420Subsystem #(
  parameter int systemClockInHz = 50000000,
  parameter logic [or1420Pkg::ciNumberWidth-1:0] swapByteId = or1420Pkg::ciSwapByte,
  parameter logic [or1420Pkg::ciNumberWidth-1:0] delayMicroId = or1420Pkg::ciDelayMicro,
  parameter int busTimeoutCycles = 64
) (
  input  wire logic                                 s_systemClock,
  input  wire logic                                 s_pllLocked,
  input  wire logic                                 ciStart,
  input  wire logic [or1420Pkg::ciNumberWidth-1:0]  ciNumber,
  input  wire logic [or1420Pkg::dataWidth-1:0]      ciDataA,
  input  wire logic [or1420Pkg::dataWidth-1:0]      ciDataB,
  output logic                                      ciDone,
  output logic [or1420Pkg::dataWidth-1:0]           ciResult,
  input  wire logic [or1420Pkg::nrOfBusMasters-1:0] busRequests,
  output logic [or1420Pkg::nrOfBusMasters-1:0]      busGrants,
  input  wire logic                                 beginTransaction,
  input  wire logic                                 endTransaction,
  input  wire logic                                 dataValid,
  output logic                                      busError,
  output logic                                      arbiterEndTransaction,
  output logic                                      busIdle
);

  localparam int ticksPerMicrosecond = systemClockInHz / 1000000;

  logic [or1420Pkg::resetCountWidth-1:0] s_resetCount;
  logic                                  s_reset;
  logic                                  s_ciStartGated;
  logic                                  s_swapByteDone;
  logic                                  s_delayDone;
  logic [or1420Pkg::dataWidth-1:0]       s_swapByteResult;
  logic [or1420Pkg::dataWidth-1:0]       s_delayResult;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reset sequencer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCount <= '0;
    end else if (!s_resetCount[or1420Pkg::resetCountWidth-1]) begin
      s_resetCount <= s_resetCount + 1'b1;   // stops once the msb is set
    end
  end

  assign s_reset = ~s_resetCount[or1420Pkg::resetCountWidth-1];

  // processor side is held off while the system is in reset
  assign s_ciStartGated = ciStart & ~s_reset;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // custom instructions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  swapByte #(
    .customInstructionId(swapByteId)
  ) swapByteInst (
    .ciStart (s_ciStartGated),
    .ciNumber(ciNumber),
    .ciDataA (ciDataA),
    .ciDataB (ciDataB),
    .ciDone  (s_swapByteDone),
    .ciResult(s_swapByteResult)
  );

  delayMicro #(
    .customInstructionId(delayMicroId),
    .ticksPerMicrosecond(ticksPerMicrosecond)
  ) delayMicroInst (
    .s_systemClock(s_systemClock),
    .reset        (s_reset),
    .ciStart      (s_ciStartGated),
    .ciNumber     (ciNumber),
    .ciDataA      (ciDataA),
    .ciDone       (s_delayDone),
    .ciResult     (s_delayResult)
  );

  // unselected units drive zeros
  assign ciDone   = s_swapByteDone | s_delayDone;
  assign ciResult = s_swapByteResult | s_delayResult;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus arbiter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  busArbiter #(
    .busTimeoutCycles(busTimeoutCycles)
  ) arbiter (
    .s_systemClock        (s_systemClock),
    .reset                (s_reset),
    .busRequests          (busRequests),
    .beginTransaction     (beginTransaction),
    .endTransaction       (endTransaction),
    .dataValid            (dataValid),
    .busGrants            (busGrants),
    .busError             (busError),
    .arbiterEndTransaction(arbiterEndTransaction),
    .busIdle              (busIdle)
  );

endmodule

`default_nettype wire

// ==== tb/or1420SubsystemTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module or1420SubsystemTb;

  localparam int clockPeriod = 20;
  localparam int systemClockInHz = 50000000;
  localparam int ticksPerMicrosecond = systemClockInHz / 1000000;
  localparam int busTimeoutCycles = 64;
  localparam int resetCycles = 16;
  localparam int swapTests = 8;
  localparam int delayTests = 6;
  localparam int arbiterRounds = 3;
  localparam int timeoutTests = 2;
  localparam int maxDoneCycles = 3 * ticksPerMicrosecond + 20;
  localparam int maxGrantCycles = 10;

  // run length from the worst case of every test
  localparam int resetTestCycles = 2 + resetCycles + 4;
  localparam int swapTestCycles = swapTests * 2 * 3;
  localparam int delayTestCycles = delayTests * (3 * ticksPerMicrosecond + 1 + 3 + 3);
  localparam int arbiterTestCycles = arbiterRounds * (or1420Pkg::nrOfBusMasters * 10 + 4);
  localparam int timeoutTestCycles = timeoutTests * (busTimeoutCycles + 6);
  localparam int watchdogCycles = resetTestCycles + swapTestCycles + delayTestCycles +
                                  arbiterTestCycles + timeoutTestCycles + 100;

  logic                                 s_systemClock;
  logic                                 s_pllLocked;
  logic                                 ciStart;
  logic [or1420Pkg::ciNumberWidth-1:0]  ciNumber;
  logic [or1420Pkg::dataWidth-1:0]      ciDataA;
  logic [or1420Pkg::dataWidth-1:0]      ciDataB;
  logic                                 ciDone;
  logic [or1420Pkg::dataWidth-1:0]      ciResult;
  logic [or1420Pkg::nrOfBusMasters-1:0] busRequests;
  logic [or1420Pkg::nrOfBusMasters-1:0] busGrants;
  logic                                 beginTransaction;
  logic                                 endTransaction;
  logic                                 dataValid;
  logic                                 busError;
  logic                                 arbiterEndTransaction;
  logic                                 busIdle;

  logic [15:0] lfsrState = 16'd52641;
  int          checkCount = 0;
  int          mismatchCount = 0;
  int          failureCount = 0;

  or1420Subsystem #(
    .systemClockInHz (systemClockInHz),
    .busTimeoutCycles(busTimeoutCycles)
  ) UUT (
    .s_systemClock        (s_systemClock),
    .s_pllLocked          (s_pllLocked),
    .ciStart              (ciStart),
    .ciNumber             (ciNumber),
    .ciDataA              (ciDataA),
    .ciDataB              (ciDataB),
    .ciDone               (ciDone),
    .ciResult             (ciResult),
    .busRequests          (busRequests),
    .busGrants            (busGrants),
    .beginTransaction     (beginTransaction),
    .endTransaction       (endTransaction),
    .dataValid            (dataValid),
    .busError             (busError),
    .arbiterEndTransaction(arbiterEndTransaction),
    .busIdle              (busIdle)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(clockPeriod / 2) s_systemClock = ~s_systemClock;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus source and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      bits = {bits[30:0], lfsrState[0]};
    end
    return bits;
  endfunction

  function automatic logic [31:0] swapModel(input logic [31:0] word, input logic halfMode);
    logic [31:0] swapped;
    int          i;
    for (i = 0; i < 4; i++) begin
      if (halfMode) begin
        swapped[8 * (i ^ 1) +: 8] = word[8 * i +: 8];   // neighbour byte
      end else begin
        swapped[8 * (3 - i) +: 8] = word[8 * i +: 8];   // mirrored byte
      end
    end
    return swapped;
  endfunction

  function automatic logic [31:0] highestRequest(input logic [31:0] requests);
    logic [31:0] grant;
    int          i;
    grant = '0;
    for (i = 31; i >= 0; i--) begin
      if (requests[i] && grant == '0) begin
        grant[i] = 1'b1;
      end
    end
    return grant;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      mismatchCount++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic reportFailure(input string what);
    failureCount++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // processor side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // counts rising edges from the start until done is seen
  task automatic awaitDone(output int cycles, output logic [31:0] result);
    cycles = 0;
    result = '0;
    @(negedge s_systemClock);
    while (!ciDone && cycles <= maxDoneCycles) begin
      @(posedge s_systemClock);
      #2;
      cycles++;
      @(negedge s_systemClock);
    end
    if (ciDone) begin
      result = ciResult;
    end else begin
      reportFailure("ciDone never came after ciStart");
      cycles = -1;
    end
  endtask

  task automatic runInstruction(input logic [7:0] number, input logic [31:0] dataA,
                                input logic [31:0] dataB, input int holdCycles,
                                output int cycles, output logic [31:0] result);
    int i;
    ciStart = 1'b1;
    ciNumber = number;
    ciDataA = dataA;
    ciDataB = dataB;
    awaitDone(cycles, result);
    for (i = 0; i < holdCycles; i++) begin
      @(posedge s_systemClock);
      #2;
      @(negedge s_systemClock);
      checkValue("ciDone", ciDone, 0);   // start still held
    end
    @(posedge s_systemClock);
    #2;
    ciStart = 1'b0;
    @(posedge s_systemClock);
    #2;
  endtask

  task automatic checkResetWindow();
    int          i;
    int          cycles;
    logic [31:0] result;
    repeat (2) @(posedge s_systemClock);
    #2;
    s_pllLocked = 1'b1;
    ciStart = 1'b1;
    ciNumber = or1420Pkg::ciSwapByte;
    ciDataA = randomBits(32);
    busRequests = randomBits(32) | 32'h1;
    for (i = 0; i < resetCycles; i++) begin
      @(negedge s_systemClock);
      checkValue("ciDone", ciDone, 0);
      checkValue("ciResult", ciResult, 0);
      checkValue("busGrants", busGrants, 0);
      checkValue("busError", busError, 0);
      checkValue("arbiterEndTransaction", arbiterEndTransaction, 0);
      checkValue("busIdle", busIdle, 1);
      @(posedge s_systemClock);
      #2;
      if (i == resetCycles / 2 - 1) begin
        ciNumber = or1420Pkg::ciDelayMicro;   // zero delay for the second half
        ciDataA = '0;
      end
    end
    busRequests = '0;
    awaitDone(cycles, result);
    checkValue("ciDone latency", cycles, 1);
    @(posedge s_systemClock);
    #2;
    ciStart = 1'b0;
    @(posedge s_systemClock);
    #2;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus masters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic awaitGrant(output int cycles);
    cycles = 0;
    @(negedge s_systemClock);
    while (busGrants == '0 && cycles <= maxGrantCycles) begin
      @(posedge s_systemClock);
      #2;
      endTransaction = 1'b0;   // end lasts one cycle
      cycles++;
      @(negedge s_systemClock);
    end
    if (busGrants == '0) begin
      reportFailure("no busGrants pulse for a pending request");
      cycles = -1;
    end else if ($countones(busGrants) != 1) begin
      reportFailure("more than one busGrants bit set at once");
    end
  endtask

  task automatic serveRequests(input logic [31:0] requests);
    logic [31:0] pending;
    logic [31:0] expected;
    logic        firstGrant;
    int          cycles;
    int          beats;
    int          i;
    pending = requests;
    busRequests = pending;
    firstGrant = 1'b1;
    while (pending != '0) begin
      expected = highestRequest(pending);
      awaitGrant(cycles);
      if (cycles < 0) begin
        pending = '0;
      end else begin
        checkValue("busGrants", busGrants, expected);
        checkValue("grant latency", cycles, firstGrant ? 1 : 2);
        firstGrant = 1'b0;
        @(posedge s_systemClock);
        #2;
        beginTransaction = 1'b1;
        pending = pending & ~expected;   // winner withdraws
        busRequests = pending;
        @(negedge s_systemClock);
        checkValue("busGrants", busGrants, 0);
        checkValue("busIdle", busIdle, 0);
        @(posedge s_systemClock);
        #2;
        beginTransaction = 1'b0;
        beats = randomBits(2);
        for (i = 0; i < beats; i++) begin
          dataValid = 1'b1;
          @(negedge s_systemClock);
          checkValue("busGrants", busGrants, 0);
          @(posedge s_systemClock);
          #2;
        end
        dataValid = 1'b0;
        endTransaction = 1'b1;
      end
    end
    busRequests = '0;
    @(posedge s_systemClock);
    #2;
    endTransaction = 1'b0;
    @(negedge s_systemClock);
    checkValue("busIdle", busIdle, 1);
    @(posedge s_systemClock);
    #2;
  endtask

  // granted master stays silent until the arbiter gives up
  task automatic abandonGrant(input logic [31:0] requests);
    int cycles;
    busRequests = requests;
    awaitGrant(cycles);
    if (cycles >= 0) begin
      checkValue("busGrants", busGrants, highestRequest(requests));
      cycles = 0;
      do begin
        @(posedge s_systemClock);
        #2;
        busRequests = '0;
        cycles++;
        @(negedge s_systemClock);
      end while (!busError && cycles <= busTimeoutCycles + 8);
      if (!busError) begin
        reportFailure("busError missing after an unused grant");
      end else begin
        checkValue("busError latency", cycles, busTimeoutCycles);
        checkValue("arbiterEndTransaction", arbiterEndTransaction, 1);
        checkValue("busIdle", busIdle, 1);
        @(posedge s_systemClock);
        #2;
        @(negedge s_systemClock);
        checkValue("busError", busError, 0);
        checkValue("arbiterEndTransaction", arbiterEndTransaction, 0);
      end
    end
    busRequests = '0;
    @(posedge s_systemClock);
    #2;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : mainSequence
    logic [31:0] dataA;
    logic [31:0] dataB;
    logic [31:0] result;
    logic [31:0] requests;
    int          cycles;
    int          delay;
    int          t;
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciNumber = '0;
    ciDataA = '0;
    ciDataB = '0;
    busRequests = '0;
    beginTransaction = 1'b0;
    endTransaction = 1'b0;
    dataValid = 1'b0;
    checkResetWindow();
    for (t = 0; t < swapTests; t++) begin
      dataA = randomBits(32);
      dataB = randomBits(32);
      runInstruction(or1420Pkg::ciSwapByte, dataA, {dataB[31:1], 1'b0}, 0, cycles, result);
      checkValue("ciDone latency", cycles, 0);
      checkValue("ciResult", result, swapModel(dataA, 1'b0));
      runInstruction(or1420Pkg::ciSwapByte, dataA, {dataB[31:1], 1'b1}, 0, cycles, result);
      checkValue("ciDone latency", cycles, 0);
      checkValue("ciResult", result, swapModel(dataA, 1'b1));
    end
    for (t = 0; t < delayTests; t++) begin
      delay = randomBits(2);
      dataB = randomBits(32);
      runInstruction(or1420Pkg::ciDelayMicro, delay, dataB, randomBits(2), cycles, result);
      checkValue("ciDone latency", cycles, delay * ticksPerMicrosecond + 1);
      checkValue("ciResult", result, 0);
    end
    for (t = 0; t < arbiterRounds; t++) begin
      requests = randomBits(32);
      serveRequests((requests == '0) ? 32'h1 : requests);
    end
    for (t = 0; t < timeoutTests; t++) begin
      requests = randomBits(32);
      abandonGrant((requests == '0) ? 32'h80000000 : requests);
    end
    $display("%0d checks, %0d mismatches, %0d other failures",
             checkCount, mismatchCount, failureCount);
    if (mismatchCount == 0 && failureCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdogCycles * clockPeriod);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/or1420Pkg.sv
customInstructions/swapByte.sv
customInstructions/delayMicro.sv
busArbiter/busArbiter.sv
source/or1420Subsystem.sv
tb/or1420SubsystemTb.sv
